//--- common/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [4:0]  shamt_t;

    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_system = 7'b1110011
    } opcode_t;

    localparam funct3_t f3_add_sub = 3'b000; // Also JALR and BEQ
    localparam funct3_t f3_sll     = 3'b001;
    localparam funct3_t f3_slt     = 3'b010;
    localparam funct3_t f3_sltu    = 3'b011;
    localparam funct3_t f3_xor     = 3'b100;
    localparam funct3_t f3_srl_sra = 3'b101;
    localparam funct3_t f3_or      = 3'b110;
    localparam funct3_t f3_and     = 3'b111;
    localparam funct3_t f3_bne     = 3'b001;
    localparam funct3_t f3_word    = 3'b010; // LW and SW
    localparam funct3_t f3_csrrw   = 3'b001;

    localparam funct7_t funct7_base = 7'b0000000;
    localparam funct7_t funct7_alt  = 7'b0100000; // SUB and SRA

    localparam inst_t ecall_inst  = 32'h0000_0073;
    localparam inst_t ebreak_inst = 32'h0010_0073;
    localparam inst_t mret_inst   = 32'h3020_0073;

    localparam csr_addr_t csr_mstatus = 12'h300;
    localparam csr_addr_t csr_mtvec   = 12'h305;
    localparam csr_addr_t csr_mepc    = 12'h341;
    localparam csr_addr_t csr_mcause  = 12'h342;

    localparam word_t ecall_cause = 32'd11; // Environment call from M-mode

endpackage

`default_nettype wire

//--- common/core_pkg.sv
`default_nettype none

package core_pkg;

    import rv_isa_pkg::*;

    localparam word_t reset_pc   = 32'h8000_0000;
    localparam int    dmem_words = 256;
    localparam word_t dmem_base  = 32'h8000_1000;

    typedef logic [$clog2(dmem_words)-1:0] dmem_idx_t;

    typedef enum logic [3:0] {
        add,
        sub,
        sll,
        slt,
        sltu,
        xor_op,
        srl,
        sra,
        or_op,
        and_op,
        pass_b
    } alu_op_t;

    typedef enum logic [1:0] {
        alu,
        mem,
        pc_plus4,
        csr
    } wb_sel_t;

    typedef enum logic {
        a_rs1,
        a_pc
    } a_sel_t;

    typedef struct packed {
        logic    reg_wen;
        logic    mem_wen;
        logic    mem_ren;
        logic    csr_wen;
        logic    is_jal;
        logic    is_jalr;
        logic    is_branch;
        logic    branch_ne; // Set for BNE, clear for BEQ
        logic    is_ecall;
        logic    is_mret;
        logic    is_ebreak;
        alu_op_t alu_op;
        a_sel_t  a_sel;
        logic    b_is_imm;
        wb_sel_t wb_sel;
    } ctrl_t;

    typedef struct packed {
        word_t    pc;
        inst_t    inst;
        reg_idx_t rd;
        logic     rd_wen;
        word_t    rd_value;
        word_t    next_pc;
    } retire_t;

endpackage

`default_nettype wire

//--- source/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  inst_t     inst,
    output reg_idx_t  rs1,
    output reg_idx_t  rs2,
    output reg_idx_t  rd,
    output word_t     imm,
    output csr_addr_t csr_addr,
    output ctrl_t     ctrl
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;
    word_t   imm_j;
    logic    shift_imm;
    logic    alt_ok;

    function automatic alu_op_t alu_from_f3(funct3_t f3, logic alt);
        alu_op_t sel;
        case (f3)
            f3_add_sub: sel = alt ? sub : add;
            f3_sll:     sel = sll;
            f3_slt:     sel = slt;
            f3_sltu:    sel = sltu;
            f3_xor:     sel = xor_op;
            f3_srl_sra: sel = alt ? sra : srl;
            f3_or:      sel = or_op;
            f3_and:     sel = and_op;
            default:    sel = add;
        endcase
        return sel;
    endfunction

    assign opcode   = opcode_t'(inst[6:0]);
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign rs1      = inst[19:15];
    assign rs2      = inst[24:20];
    assign rd       = inst[11:7];
    assign csr_addr = inst[31:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign shift_imm = (funct3 == f3_sll) || (funct3 == f3_srl_sra);
    // SUB and SRA/SRAI are the only legal uses of the alternate funct7
    assign alt_ok    = (funct7 == funct7_alt) && ((funct3 == f3_add_sub) || (funct3 == f3_srl_sra));

    always_comb begin
        ctrl        = '0; // Unknown encodings fall through as a no-op
        ctrl.alu_op = add;
        ctrl.a_sel  = a_rs1;
        ctrl.wb_sel = alu;
        imm         = imm_i;
        case (opcode)
            opc_lui: begin
                imm           = imm_u;
                ctrl.reg_wen  = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.alu_op   = pass_b;
            end
            opc_auipc: begin
                imm           = imm_u;
                ctrl.reg_wen  = 1'b1;
                ctrl.a_sel    = a_pc;
                ctrl.b_is_imm = 1'b1;
            end
            opc_jal: begin
                imm          = imm_j;
                ctrl.reg_wen = 1'b1;
                ctrl.is_jal  = 1'b1;
                ctrl.wb_sel  = pc_plus4;
            end
            opc_jalr: begin
                if (funct3 == f3_add_sub) begin
                    ctrl.reg_wen  = 1'b1;
                    ctrl.is_jalr  = 1'b1;
                    ctrl.b_is_imm = 1'b1;
                    ctrl.wb_sel   = pc_plus4;
                end
            end
            opc_branch: begin
                imm = imm_b;
                if ((funct3 == f3_add_sub) || (funct3 == f3_bne)) begin
                    ctrl.is_branch = 1'b1;
                    ctrl.branch_ne = (funct3 == f3_bne);
                    ctrl.alu_op    = sub; // Zero result means equal
                end
            end
            opc_load: begin
                if (funct3 == f3_word) begin
                    ctrl.reg_wen  = 1'b1;
                    ctrl.mem_ren  = 1'b1;
                    ctrl.b_is_imm = 1'b1;
                    ctrl.wb_sel   = mem;
                end
            end
            opc_store: begin
                imm = imm_s;
                if (funct3 == f3_word) begin
                    ctrl.mem_wen  = 1'b1;
                    ctrl.b_is_imm = 1'b1;
                end
            end
            opc_op_imm: begin
                if (!shift_imm || (funct7 == funct7_base) || alt_ok) begin
                    ctrl.reg_wen  = 1'b1;
                    ctrl.b_is_imm = 1'b1;
                    ctrl.alu_op   = alu_from_f3(funct3, shift_imm && funct7[5]);
                end
            end
            opc_op: begin
                if ((funct7 == funct7_base) || alt_ok) begin
                    ctrl.reg_wen = 1'b1;
                    ctrl.alu_op  = alu_from_f3(funct3, funct7 == funct7_alt);
                end
            end
            opc_system: begin
                if (inst == ecall_inst) begin
                    ctrl.is_ecall = 1'b1;
                end else if (inst == mret_inst) begin
                    ctrl.is_mret = 1'b1;
                end else if (inst == ebreak_inst) begin
                    ctrl.is_ebreak = 1'b1;
                end else if (funct3 == f3_csrrw) begin
                    ctrl.reg_wen = 1'b1;
                    ctrl.csr_wen = 1'b1;
                    ctrl.wb_sel  = csr;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  alu_op_t op,
    input  a_sel_t  a_sel,
    input  logic    b_is_imm,
    input  word_t   pc,
    input  word_t   rs1_value,
    input  word_t   rs2_value,
    input  word_t   imm,
    output word_t   result
);

    word_t  a;
    word_t  b;
    shamt_t shamt;

    assign a     = (a_sel == a_pc) ? pc : rs1_value;
    assign b     = b_is_imm ? imm : rs2_value;
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            add:     result = a + b;
            sub:     result = a - b;
            sll:     result = a << shamt;
            slt:     result = {31'b0, $signed(a) < $signed(b)};
            sltu:    result = {31'b0, a < b};
            xor_op:  result = a ^ b;
            srl:     result = a >> shamt;
            sra:     result = word_t'($signed(a) >>> shamt);
            or_op:   result = a | b;
            and_op:  result = a & b;
            pass_b:  result = b; // LUI
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import rv_isa_pkg::*;
(
    input  logic     clk,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  logic     wen,
    input  word_t    wdata,
    output word_t    rs1_value,
    output word_t    rs2_value
);

    word_t regs [1:31]; // No storage behind x0

    always_ff @(posedge clk) begin
        if (wen && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    // Reads see the value from the previous edge
    assign rs1_value = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- source/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file
    import rv_isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  csr_addr_t addr,
    input  logic      wen,
    input  word_t     wdata,
    input  logic      ecall,
    input  word_t     pc,
    output word_t     rdata,
    output word_t     mepc,
    output word_t     mtvec
);

    word_t mcause;
    word_t mstatus;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mepc    <= '0;
            mcause  <= '0;
            mstatus <= '0;
            mtvec   <= '0;
        end else if (ecall) begin
            mepc   <= pc; // Trap returns to the ECALL itself
            mcause <= ecall_cause;
        end else if (wen) begin
            case (addr)
                csr_mepc:    mepc    <= wdata;
                csr_mcause:  mcause  <= wdata;
                csr_mstatus: mstatus <= wdata;
                csr_mtvec:   mtvec   <= wdata;
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        case (addr)
            csr_mepc:    rdata = mepc;
            csr_mcause:  rdata = mcause;
            csr_mstatus: rdata = mstatus;
            csr_mtvec:   rdata = mtvec;
            default:     rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  logic  clk,
    input  word_t addr,
    input  logic  wen,
    input  word_t wdata,
    output word_t rdata
);

    word_t     mem [0:dmem_words-1];
    word_t     offset;
    dmem_idx_t idx;

    assign offset = addr - dmem_base;
    // Word index wraps around the array
    assign idx    = offset[2 +: $bits(dmem_idx_t)];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];

endmodule

`default_nettype wire

//--- source/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  inst_t   imem_data,
    output word_t   imem_addr,
    output logic    retire_valid,
    output retire_t retire,
    output logic    halted
);

    word_t     pc;
    word_t     seq_pc;
    word_t     next_pc;
    word_t     wb_value;
    word_t     load_data;
    logic      active;
    logic      branch_taken;
    ctrl_t     ctrl;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    word_t     imm;
    csr_addr_t csr_addr;
    word_t     rs1_value;
    word_t     rs2_value;
    word_t     alu_result;
    word_t     csr_rdata;
    word_t     mepc;
    word_t     mtvec;
    word_t     mem_rdata;

    assign active       = rst_n && !halted; // Nothing commits in reset or after EBREAK
    assign seq_pc       = pc + 32'd4;
    assign branch_taken = ctrl.is_branch && ((alu_result == '0) ^ ctrl.branch_ne);
    assign load_data    = ctrl.mem_ren ? mem_rdata : '0;

    always_comb begin
        if (ctrl.is_ebreak) begin
            next_pc = pc; // The core parks on the EBREAK
        end else if (ctrl.is_mret) begin
            next_pc = mepc;
        end else if (ctrl.is_ecall) begin
            next_pc = mtvec;
        end else if (ctrl.is_jal) begin
            next_pc = pc + imm;
        end else if (ctrl.is_jalr) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else if (branch_taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = seq_pc;
        end
    end

    always_comb begin
        case (ctrl.wb_sel)
            mem:      wb_value = load_data;
            pc_plus4: wb_value = seq_pc;
            csr:      wb_value = csr_rdata; // Old CSR value for CSRRW
            default:  wb_value = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= reset_pc;
            halted <= 1'b0;
        end else if (!halted) begin
            pc     <= next_pc;
            halted <= ctrl.is_ebreak;
        end
    end

    assign imem_addr    = pc;
    assign retire_valid = active;

    always_comb begin
        retire          = '0;
        retire.pc       = pc;
        retire.inst     = imem_data;
        retire.rd       = rd;
        retire.rd_wen   = ctrl.reg_wen && active;
        retire.rd_value = wb_value;
        retire.next_pc  = next_pc;
    end

    decoder u_decoder (
        .inst     (imem_data),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .imm      (imm),
        .csr_addr (csr_addr),
        .ctrl     (ctrl)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .wen       (ctrl.reg_wen && active),
        .wdata     (wb_value),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    alu u_alu (
        .op        (ctrl.alu_op),
        .a_sel     (ctrl.a_sel),
        .b_is_imm  (ctrl.b_is_imm),
        .pc        (pc),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .imm       (imm),
        .result    (alu_result)
    );

    csr_file u_csr_file (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (csr_addr),
        .wen   (ctrl.csr_wen && active),
        .wdata (rs1_value),
        .ecall (ctrl.is_ecall && active),
        .pc    (pc),
        .rdata (csr_rdata),
        .mepc  (mepc),
        .mtvec (mtvec)
    );

    data_mem u_data_mem (
        .clk   (clk),
        .addr  (alu_result),
        .wen   (ctrl.mem_wen && active),
        .wdata (rs2_value),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

//--- tests/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core
    import rv_isa_pkg::*;
    import core_pkg::*;
;

    localparam int num_programs = 4;

    logic    clk = 1'b0;
    logic    rst_n;
    inst_t   imem_data;
    word_t   imem_addr;
    logic    retire_valid;
    retire_t trace;
    logic    halted;

    inst_t   imem [0:127];
    retire_t exp_q [$];
    int      exp_ptr;
    word_t   cur_pc;
    int      seed;
    int      budget;
    int      trace_errs;
    int      assert_errs;

    always #4 clk = ~clk;

    assign imem_data = imem[imem_addr[8:2]]; // Same-cycle instruction port

    core_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_data    (imem_data),
        .imem_addr    (imem_addr),
        .retire_valid (retire_valid),
        .retire       (trace),
        .halted       (halted)
    );

    function automatic word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic inst_t enc_i(logic [11:0] imm, reg_idx_t rs1, funct3_t f3,
                                    reg_idx_t rd, opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_r(funct7_t f7, reg_idx_t rs2, reg_idx_t rs1,
                                    funct3_t f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic inst_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, f3_word, imm[4:0], opc_store};
    endfunction

    function automatic inst_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic inst_t enc_u(logic [19:0] imm, reg_idx_t rd, opcode_t opc);
        return {imm, rd, opc};
    endfunction

    function automatic inst_t enc_j(logic [20:0] imm, reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    // Places one instruction at cur_pc and queues the record it must retire with
    task automatic emit(inst_t inst, logic wen, reg_idx_t rd, word_t value, word_t next);
        retire_t r;
        r          = '0;
        r.pc       = cur_pc;
        r.inst     = inst;
        r.rd       = rd;
        r.rd_wen   = wen;
        r.rd_value = value;
        r.next_pc  = next;
        imem[cur_pc[8:2]] = inst;
        exp_q.push_back(r);
        cur_pc = next;
    endtask

    task automatic seq_write(inst_t inst, reg_idx_t rd, word_t value);
        emit(inst, 1'b1, rd, value, cur_pc + 32'd4);
    endtask

    task automatic seq_nowrite(inst_t inst);
        emit(inst, 1'b0, '0, '0, cur_pc + 32'd4);
    endtask

    task automatic build_program(int n);
        word_t       r;
        word_t       value;
        word_t       link;
        word_t       handler;
        word_t       ecall_pc;
        word_t       model [1:4];
        reg_idx_t    a;
        reg_idx_t    b;
        reg_idx_t    d;
        logic [11:0] imm;
        foreach (imem[i]) imem[i] = ebreak_inst; // Stray fetches halt the core
        exp_q.delete();
        cur_pc = reset_pc;
        case (n)
            0: begin
                seq_write(enc_u(20'h12345, 1, opc_lui), 1, 32'h1234_5000);
                seq_write(enc_u(20'h00001, 2, opc_auipc), 2, cur_pc + 32'h1000);
                seq_write(enc_i(12'hFFB, 0, f3_add_sub, 3, opc_op_imm), 3, 32'hFFFF_FFFB);
                seq_write(enc_i(12'h007, 0, f3_add_sub, 4, opc_op_imm), 4, 32'd7);
                seq_write(enc_r(funct7_alt, 3, 4, f3_add_sub, 5), 5, 32'd12);
                seq_write(enc_i(12'h004, 4, f3_sll, 6, opc_op_imm), 6, 32'h70);
                seq_write(enc_i(12'h401, 3, f3_srl_sra, 7, opc_op_imm), 7, 32'hFFFF_FFFD);
                seq_write(enc_i(12'h01C, 3, f3_srl_sra, 8, opc_op_imm), 8, 32'hF);
                seq_write(enc_r(funct7_base, 4, 4, f3_sll, 9), 9, 32'h380);
                seq_write(enc_r(funct7_base, 4, 3, f3_slt, 10), 10, 32'd1);
                seq_write(enc_r(funct7_base, 4, 3, f3_sltu, 11), 11, 32'd0);
                seq_write(enc_i(12'h005, 4, f3_add_sub, 0, opc_op_imm), 0, 32'd12);
                seq_write(enc_r(funct7_base, 4, 0, f3_add_sub, 12), 12, 32'd7); // x0 still zero
                seq_write(enc_r(funct7_base, 4, 3, f3_or, 13), 13, 32'hFFFF_FFFF);
                seq_write(enc_r(funct7_base, 4, 3, f3_and, 14), 14, 32'd3);
            end
            1: begin
                seq_write(enc_u(20'h80001, 1, opc_lui), 1, dmem_base);
                seq_write(enc_i(12'h05A, 0, f3_add_sub, 2, opc_op_imm), 2, 32'h5A);
                seq_write(enc_u(20'hCAFEB, 3, opc_lui), 3, 32'hCAFE_B000);
                seq_write(enc_i(12'hEF0, 3, f3_add_sub, 3, opc_op_imm), 3, 32'hCAFE_AEF0);
                seq_nowrite(enc_s(12'h000, 2, 1));
                seq_nowrite(enc_s(12'h008, 3, 1));
                seq_write(enc_i(12'h000, 1, f3_word, 4, opc_load), 4, 32'h5A);
                seq_write(enc_i(12'h008, 1, f3_word, 5, opc_load), 5, 32'hCAFE_AEF0);
                seq_nowrite(enc_s(12'h004, 5, 1));
                seq_write(enc_i(12'h004, 1, f3_word, 6, opc_load), 6, 32'hCAFE_AEF0);
                emit(enc_b(13'd8, 2, 4, f3_add_sub), 1'b0, '0, '0, cur_pc + 32'd8);
                emit(enc_b(13'd8, 2, 4, f3_bne), 1'b0, '0, '0, cur_pc + 32'd4);
                emit(enc_b(13'd12, 5, 4, f3_bne), 1'b0, '0, '0, cur_pc + 32'd12);
                emit(enc_b(13'd8, 5, 4, f3_add_sub), 1'b0, '0, '0, cur_pc + 32'd4);
                emit(enc_j(21'd16, 7), 1'b1, 7, cur_pc + 32'd4, cur_pc + 32'd16);
                seq_write(enc_u(20'h00000, 9, opc_auipc), 9, cur_pc);
                link = cur_pc + 32'd4;
                // Target is odd before bit 0 is cleared
                emit(enc_i(12'd13, 9, f3_add_sub, 8, opc_jalr), 1'b1, 8, link,
                     cur_pc + 32'd8);
                seq_write(enc_i(12'h001, 8, f3_add_sub, 10, opc_op_imm), 10, link + 32'd1);
            end
            2: begin
                handler = reset_pc + 32'h100;
                seq_write(enc_u(20'h80000, 1, opc_lui), 1, reset_pc);
                seq_write(enc_i(12'h100, 1, f3_add_sub, 1, opc_op_imm), 1, handler);
                seq_write(enc_i(csr_mtvec, 1, f3_csrrw, 2, opc_system), 2, 32'd0);
                seq_write(enc_i(csr_mtvec, 1, f3_csrrw, 3, opc_system), 3, handler);
                ecall_pc = cur_pc;
                emit(ecall_inst, 1'b0, '0, '0, handler);
                seq_write(enc_i(csr_mcause, 0, f3_csrrw, 4, opc_system), 4, 32'd11);
                seq_write(enc_i(csr_mepc, 0, f3_csrrw, 5, opc_system), 5, ecall_pc);
                seq_write(enc_i(12'h004, 5, f3_add_sub, 5, opc_op_imm), 5, ecall_pc + 32'd4);
                seq_write(enc_i(csr_mepc, 5, f3_csrrw, 0, opc_system), 0, 32'd0);
                emit(mret_inst, 1'b0, '0, '0, ecall_pc + 32'd4);
                seq_write(enc_i(12'h001, 0, f3_add_sub, 6, opc_op_imm), 6, 32'd1);
                seq_write(enc_i(csr_mstatus, 6, f3_csrrw, 7, opc_system), 7, 32'd0);
                seq_write(enc_i(csr_mstatus, 0, f3_csrrw, 8, opc_system), 8, 32'd1);
            end
            default: begin
                seed = 32'h5b2b4d0b; // Same stream on every build
                for (int k = 1; k <= 4; k++) begin
                    r   = $random(seed);
                    imm = r[11:0];
                    model[k] = sext12(imm);
                    seq_write(enc_i(imm, 0, f3_add_sub, k, opc_op_imm), k, model[k]);
                end
                for (int k = 0; k < 16; k++) begin
                    r = $random(seed);
                    a = 5'd1 + r[1:0];
                    b = 5'd1 + r[3:2];
                    d = 5'd1 + r[5:4];
                    if (r[31]) begin
                        value = model[a] + model[b];
                        seq_write(enc_r(funct7_base, b, a, f3_add_sub, d), d, value);
                    end else begin
                        imm   = r[27:16];
                        value = model[a] + sext12(imm);
                        seq_write(enc_i(imm, a, f3_add_sub, d, opc_op_imm), d, value);
                    end
                    model[d] = value;
                end
            end
        endcase
        emit(ebreak_inst, 1'b0, '0, '0, cur_pc);
    endtask

    task automatic compare_field(string name, word_t got, word_t exp);
        assert (got === exp) else begin
            trace_errs++;
            $display("ERR %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_retire();
        retire_t e;
        if (exp_ptr >= exp_q.size()) begin
            trace_errs++;
            $display("The core retired an instruction at %h past the end of the program",
                     trace.pc);
        end else begin
            e = exp_q[exp_ptr];
            compare_field("pc", trace.pc, e.pc);
            compare_field("inst", trace.inst, e.inst);
            compare_field("rd_wen", word_t'(trace.rd_wen), word_t'(e.rd_wen));
            compare_field("next_pc", trace.next_pc, e.next_pc);
            if (e.rd_wen) begin
                compare_field("rd", word_t'(trace.rd), word_t'(e.rd));
                compare_field("rd_value", trace.rd_value, e.rd_value);
            end
            exp_ptr++;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && retire_valid) begin
            check_retire();
        end
    end

    assert property (@(posedge clk) !rst_n |-> !retire_valid) else begin
        assert_errs++;
        $display("ERR %0t: retire_valid high during reset", $time);
    end

    assert property (@(posedge clk) $rose(rst_n) |-> imem_addr == reset_pc) else begin
        assert_errs++;
        $display("ERR %0t: first fetch at %h instead of reset_pc", $time, imem_addr);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
                     halted |=> halted && $stable(imem_addr)) else begin
        assert_errs++;
        $display("ERR %0t: halted core left its EBREAK", $time);
    end

    assert property (@(posedge clk) halted |-> !retire_valid) else begin
        assert_errs++;
        $display("ERR %0t: retire_valid high while halted", $time);
    end

    task automatic run_program(int n);
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        build_program(n);
        exp_ptr = 0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!halted);
        repeat (3) @(posedge clk); // The halt assertions watch these cycles
        assert (exp_ptr == exp_q.size() && imem_addr == exp_q[$].pc) else begin
            trace_errs++;
            $display("Program %0d retired %0d of %0d instructions and parked at %h",
                     n, exp_ptr, exp_q.size(), imem_addr);
        end
    endtask

    initial begin
        int total_len;
        rst_n       = 1'b0;
        trace_errs  = 0;
        assert_errs = 0;
        budget      = 0;
        exp_ptr     = 0;
        total_len   = 0;
        for (int n = 0; n < num_programs; n++) begin
            build_program(n);
            total_len += exp_q.size();
        end
        budget = total_len + num_programs * 16 + 20; // Reset and halt cycles per program
        for (int n = 0; n < num_programs; n++) begin
            run_program(n);
        end
        $display("Errors: %0d trace, %0d assertion", trace_errs, assert_errs);
        if (trace_errs + assert_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (budget > 0);
        #(budget * 8);
        $display("Timeout: the core did not halt within %0d cycles", budget);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
common/rv_isa_pkg.sv
common/core_pkg.sv
source/decoder.sv
source/alu.sv
source/reg_file.sv
source/csr_file.sv
source/data_mem.sv
source/core_top.sv
tests/tb_core.sv
